//--- sources.f
design/datapath_pkg.sv
design/reg_file.sv
design/special_regs.sv
design/alu.sv
design/bus.sv
design/datapath_top.sv
dv/datapath_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f sources.f \
	--top-module datapath_tb \
	-Mdir obj_dir \
	-o datapath_sim

./obj_dir/datapath_sim > sim.log 2>&1
cat sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi

//--- dv/datapath_trace.txt
# name sel load op mdata_in inport_data check expected_bus
# fields after the name are hex; check 1 compares bus_value with expected_bus
pc_reset 100000 0000000 0 00000000 00000000 1 00000000
pc_inc 000000 2000000 0 00000000 00000000 1 00000000
pc_inc 100000 2000000 0 00000000 00000000 1 00000004
pc_inc 100000 0000000 0 00000000 00000000 1 00000008
pc_override 000000 1100000 0 00000100 00000000 0 00000000
pc_override 200000 2080000 0 00000000 00000000 1 00000100
pc_override 100000 0000000 0 00000000 00000000 1 00000100
reg_mdr_r3 000000 1100000 0 deadbeef 00000000 0 00000000
reg_mdr_r3 200000 0000008 0 00000000 00000000 1 deadbeef
reg_mdr_r3 000008 0000000 0 00000000 00000000 1 deadbeef
reg_inport_r15 000000 0800000 0 00000000 13579bdf 0 00000000
reg_inport_r15 400000 0008000 0 00000000 00000000 1 13579bdf
reg_inport_r15 008000 0000000 0 00000000 00000000 1 13579bdf
bus_priority 000000 1100000 0 0000002a 00000000 0 00000000
bus_priority 200000 0000004 0 00000000 00000000 1 0000002a
bus_priority 100004 0000000 0 00000000 00000000 1 0000002a
bus_priority a00000 0000000 0 00000000 00000000 1 0000002a
bus_idle 000000 0000000 0 00000000 00000000 1 00000000
alu_setup 000000 1100000 0 f00f1234 00000000 0 00000000
alu_setup 200000 0000002 0 00000000 00000000 1 f00f1234
alu_setup 000000 1100000 0 0f0f0f0f 00000000 0 00000000
alu_setup 200000 0000010 0 00000000 00000000 1 0f0f0f0f
alu_setup 000000 1100000 0 00000024 00000000 0 00000000
alu_setup 200000 0000020 0 00000000 00000000 1 00000024
alu_setup 000002 0400000 0 00000000 00000000 1 f00f1234
alu_add 000010 0040000 0 00000000 00000000 1 0f0f0f0f
alu_add 080000 0000000 0 00000000 00000000 1 ff1e2143
alu_sub 000010 0040000 1 00000000 00000000 1 0f0f0f0f
alu_sub 080000 0000000 0 00000000 00000000 1 e1000325
alu_and 000010 0040000 2 00000000 00000000 1 0f0f0f0f
alu_and 080000 0000000 0 00000000 00000000 1 000f0204
alu_or 000010 0040000 3 00000000 00000000 1 0f0f0f0f
alu_or 080000 0000000 0 00000000 00000000 1 ff0f1f3f
alu_shl 000020 0040000 6 00000000 00000000 1 00000024
alu_shl 080000 0000000 0 00000000 00000000 1 00f12340
alu_shr 000020 0040000 4 00000000 00000000 1 00000024
alu_shr 080000 0000000 0 00000000 00000000 1 0f00f123
alu_shra 000020 0040000 5 00000000 00000000 1 00000024
alu_shra 080000 0000000 0 00000000 00000000 1 ff00f123
alu_rol 000020 0040000 8 00000000 00000000 1 00000024
alu_rol 080000 0000000 0 00000000 00000000 1 00f1234f
alu_ror 000020 0040000 7 00000000 00000000 1 00000024
alu_ror 080000 0000000 0 00000000 00000000 1 4f00f123
alu_neg 000010 0040000 a 00000000 00000000 1 0f0f0f0f
alu_neg 080000 0000000 0 00000000 00000000 1 f0f0f0f1
alu_not 000010 0040000 b 00000000 00000000 1 0f0f0f0f
alu_not 080000 0000000 0 00000000 00000000 1 f0f0f0f0
alu_mul 000000 1100000 0 fff00000 00000000 0 00000000
alu_mul 200000 0400000 0 00000000 00000000 1 fff00000
alu_mul 000000 1100000 0 00123456 00000000 0 00000000
alu_mul 200000 0040000 9 00000000 00000000 1 00123456
alu_mul 040000 0000000 0 00000000 00000000 1 fffffedc
alu_mul 080000 0000000 0 00000000 00000000 1 baa00000
base_zero_on 000000 1100000 0 cafe0001 00000000 0 00000000
base_zero_on 200000 0000001 0 00000000 00000000 1 cafe0001
base_zero_on 000001 0000000 0 00000000 00000000 1 00000000
const_sext 000000 1100000 0 491ffffb 00000000 0 00000000
const_sext 200000 0200000 0 00000000 00000000 1 491ffffb
const_sext 800000 0000000 0 00000000 00000000 1 fffffffb
base_zero_off 000001 0000000 0 00000000 00000000 1 cafe0001

//--- dv/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb;

	import datapath_pkg::*;

	// one trace line.
	typedef struct packed {
		bus_sel_t    sel;
		reg_load_t   load;
		logic [3:0]  op;
		logic [31:0] mdata;
		logic [31:0] inport;
		logic        chk;
		logic [31:0] expected;
	} step_t;

	logic        clk;
	logic        arst_n;
	bus_sel_t    sel;
	reg_load_t   load;
	alu_op_e     op;
	logic [31:0] mdata_in;
	logic [31:0] inport_data;
	logic [31:0] bus_value;

	step_t steps[$];
	string names[$];
	int    cycles;
	int    cycle_limit;
	int    test_errors;
	int    tests_passed;
	int    tests_failed;

	datapath_top #(
		.PC_RESET (32'h0000_0000)
	) u_datapath_top (
		.clk         (clk),
		.arst_n      (arst_n),
		.sel         (sel),
		.load        (load),
		.op          (op),
		.mdata_in    (mdata_in),
		.inport_data (inport_data),
		.bus_value   (bus_value)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the trace did not complete within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
		else
			cycles <= cycles + 1;
	end

	task automatic check_value(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0)
		begin
			$display("%s: ok", name);
			tests_passed++;
		end
		else
		begin
			$display("%s: failed with %0d mismatches", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic load_trace(output bit ok);
		int          fd;
		int          fields;
		string       text;
		string       name;
		logic [23:0] sel_word;
		logic [25:0] load_word;
		logic [3:0]  op_word;
		logic [31:0] mdata_word;
		logic [31:0] inport_word;
		logic        chk_word;
		logic [31:0] exp_word;
		step_t       step;
		ok = 1'b0;
		fd = $fopen("dv/datapath_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the trace file dv/datapath_trace.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				text = "";
				void'($fgets(text, fd));
				// skip blank and comment lines.
				if (text.len() > 1 && text.getc(0) != "#")
				begin
					fields = $sscanf(text, "%s %h %h %h %h %h %h %h", name, sel_word,
						load_word, op_word, mdata_word, inport_word, chk_word, exp_word);
					if (fields == 8)
					begin
						step.sel      = sel_word;
						step.load     = load_word;
						step.op       = op_word;
						step.mdata    = mdata_word;
						step.inport   = inport_word;
						step.chk      = chk_word;
						step.expected = exp_word;
						steps.push_back(step);
						names.push_back(name);
					end
				end
			end
			$fclose(fd);
			if (steps.size() == 0)
				$display("the trace file holds no steps");
			else
				ok = 1'b1;
		end
	endtask

	task automatic run_trace();
		for (int k = 0; k < steps.size(); k++)
		begin
			@(posedge clk);
			sel         <= steps[k].sel;
			load        <= steps[k].load;
			op          <= alu_op_e'(steps[k].op);
			mdata_in    <= steps[k].mdata;
			inport_data <= steps[k].inport;
			// bus is settled by the falling edge.
			@(negedge clk);
			if (steps[k].chk)
				check_value(names[k], steps[k].expected, bus_value);
			if (k == steps.size() - 1 || names[k + 1] != names[k])
				close_test(names[k]);
		end
	endtask

	initial
	begin
		bit loaded;
		clk          = 1'b0;
		arst_n       = 1'b0;
		sel          = '0;
		load         = '0;
		op           = alu_add;
		mdata_in     = '0;
		inport_data  = '0;
		cycles       = 0;
		cycle_limit  = 0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;
		load_trace(loaded);
		if (!loaded)
		begin
			$display("TEST RESULT: FAIL");
			$finish;
		end
		else
		begin
			// reset, one cycle per step, and some margin.
			cycle_limit = 4 + steps.size() + 20;
			repeat (4) @(posedge clk);
			arst_n <= 1'b1;
			run_trace();
			$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
			if (tests_failed == 0)
				$display("TEST RESULT: PASS");
			else
				$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

//--- design/datapath_top.sv
`timescale 1ns/1ps

module datapath_top #(
	parameter logic [31:0] PC_RESET = 32'h0000_0000
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  datapath_pkg::bus_sel_t  sel,
	input  datapath_pkg::reg_load_t load,
	input  datapath_pkg::alu_op_e   op,
	input  logic [31:0]             mdata_in,
	input  logic [31:0]             inport_data,
	output logic [31:0]             bus_value
);

	import datapath_pkg::*;

	gpr_sources_t     gpr;
	special_sources_t special;
	logic [31:0]      y_value;
	logic [63:0]      alu_result;
	logic             base_zero;

	reg_file u_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.load      (load),
		.base_zero (base_zero),
		.bus_word  (bus_value),
		.gpr       (gpr)
	);

	special_regs #(
		.PC_RESET (PC_RESET)
	) u_special_regs (
		.clk         (clk),
		.arst_n      (arst_n),
		.load        (load),
		.bus_word    (bus_value),
		.alu_result  (alu_result),
		.mdata_in    (mdata_in),
		.inport_data (inport_data),
		.y_value     (y_value),
		.base_zero   (base_zero),
		.special     (special)
	);

	// y is the first operand, the bus the second.
	alu u_alu (
		.op     (op),
		.a      (y_value),
		.b      (bus_value),
		.result (alu_result)
	);

	bus u_bus (
		.sel      (sel),
		.gpr      (gpr),
		.special  (special),
		.bus_word (bus_value)
	);

endmodule

//--- design/bus.sv
`timescale 1ns/1ps

module bus (
	input  datapath_pkg::bus_sel_t         sel,
	input  datapath_pkg::gpr_sources_t     gpr,
	input  datapath_pkg::special_sources_t special,
	output logic [31:0]                    bus_word
);

	logic [23:0] strobes;
	logic [4:0]  src_idx;
	logic        src_valid;

	// bit 0 is r0, bit 23 is the constant.
	assign strobes = {
		sel.c_out,
		sel.inport_out,
		sel.mdr_out,
		sel.pc_out,
		sel.zlow_out,
		sel.zhigh_out,
		sel.lo_out,
		sel.hi_out,
		sel.r_out
	};

	// lowest set strobe wins.
	always_comb
	begin
		src_idx   = '0;
		src_valid = 1'b0;
		for (int i = 23; i >= 0; i--)
		begin
			if (strobes[i])
			begin
				src_idx   = 5'(i);
				src_valid = 1'b1;
			end
		end
	end

	// idle bus reads zero.
	always_comb
	begin
		if (!src_valid)
			bus_word = '0;
		else if (!src_idx[4])
			bus_word = gpr[src_idx[3:0]];
		else
		begin
			case (src_idx[2:0])
				3'd0:    bus_word = special.hi;
				3'd1:    bus_word = special.lo;
				3'd2:    bus_word = special.zhigh;
				3'd3:    bus_word = special.zlow;
				3'd4:    bus_word = special.pc;
				3'd5:    bus_word = special.mdr;
				3'd6:    bus_word = special.inport;
				default: bus_word = special.c_sext;
			endcase
		end
	end

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
	input  datapath_pkg::alu_op_e op,
	input  logic [31:0]           a,
	input  logic [31:0]           b,
	output logic [63:0]           result
);

	import datapath_pkg::*;

	logic [4:0]  amt;
	logic [63:0] doubled;
	logic [63:0] rol_word;
	logic [63:0] product;
	logic [31:0] low;

	assign amt = b[4:0];

	// rotates come out of a doubled copy of a.
	assign doubled  = {a, a};
	assign rol_word = doubled << amt;

	// low 64 bits of the extended product is the signed product.
	assign product = {{32{a[31]}}, a} * {{32{b[31]}}, b};

	always_comb
	begin
		case (op)
			alu_add:
				low = a + b;
			alu_sub:
				low = a - b;
			alu_and:
				low = a & b;
			alu_or:
				low = a | b;
			alu_shr:
				low = a >> amt;
			alu_shra:
				low = $signed(a) >>> amt;
			alu_shl:
				low = a << amt;
			alu_ror:
				low = 32'(doubled >> amt);
			alu_rol:
				low = rol_word[63:32];
			alu_neg:
				low = -b;
			alu_not:
				low = ~b;
			alu_inc4:
				low = b + 32'd4;
			default:
				low = '0;
		endcase
	end

	// wide result for mul, sign copy otherwise.
	assign result = (op == alu_mul) ? product : {{32{low[31]}}, low};

endmodule

//--- design/special_regs.sv
`timescale 1ns/1ps

module special_regs #(
	parameter logic [31:0] PC_RESET = 32'h0000_0000
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  datapath_pkg::reg_load_t        load,
	input  logic [31:0]                    bus_word,
	input  logic [63:0]                    alu_result,
	input  logic [31:0]                    mdata_in,
	input  logic [31:0]                    inport_data,
	output logic [31:0]                    y_value,
	output logic                           base_zero,
	output datapath_pkg::special_sources_t special
);

	import datapath_pkg::*;

	logic [31:0] hi_q;
	logic [31:0] lo_q;
	logic [63:0] z_q;
	logic [31:0] pc_q;
	logic [31:0] mdr_q;
	logic [31:0] inport_q;
	logic [31:0] y_q;
	inst_word_u  ir_q;

	// plain bus loads.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hi_q <= '0;
			lo_q <= '0;
			y_q  <= '0;
			ir_q <= '0;
		end
		else
		begin
			if (load.hi_in)
				hi_q <= bus_word;
			if (load.lo_in)
				lo_q <= bus_word;
			if (load.y_in)
				y_q <= bus_word;
			if (load.ir_in)
				ir_q <= bus_word;
		end
	end

	// z, mdr and the input port have their own sources.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			z_q      <= '0;
			mdr_q    <= '0;
			inport_q <= '0;
		end
		else
		begin
			if (load.z_in)
				z_q <= alu_result;
			if (load.mdr_in)
				mdr_q <= load.mdr_read ? mdata_in : bus_word;
			if (load.inport_in)
				inport_q <= inport_data;
		end
	end

	// a bus load beats the increment.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pc_q <= PC_RESET;
		else if (load.pc_in)
			pc_q <= bus_word;
		else if (load.inc_pc)
			pc_q <= pc_q + 32'd4;
	end

	assign y_value   = y_q;
	assign base_zero = (ir_q.rtype.rb == 4'd0);

	assign special.hi     = hi_q;
	assign special.lo     = lo_q;
	assign special.zhigh  = z_q[63:32];
	assign special.zlow   = z_q[31:0];
	assign special.pc     = pc_q;
	assign special.mdr    = mdr_q;
	assign special.inport = inport_q;
	assign special.c_sext = {{13{ir_q.itype.constant[18]}}, ir_q.itype.constant};

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                       clk,
	input  logic                       arst_n,
	input  datapath_pkg::reg_load_t    load,
	input  logic                       base_zero,
	input  logic [31:0]                bus_word,
	output datapath_pkg::gpr_sources_t gpr
);

	import datapath_pkg::*;

	gpr_sources_t regs;

	// each register takes the bus under its own in strobe.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			regs <= '0;
		end
		else
		begin
			for (int i = 0; i < 16; i++)
			begin
				if (load.r_in[i])
				begin
					regs[i] <= bus_word;
				end
			end
		end
	end

	// r0 reads as zero when used as a base.
	always_comb
	begin
		gpr = regs;
		if (base_zero)
		begin
			gpr[0] = '0;
		end
	end

endmodule

//--- design/datapath_pkg.sv
package datapath_pkg;

	// out strobes, one per bus source.
	typedef struct packed {
		logic        c_out;
		logic        inport_out;
		logic        mdr_out;
		logic        pc_out;
		logic        zlow_out;
		logic        zhigh_out;
		logic        lo_out;
		logic        hi_out;
		logic [15:0] r_out;
	} bus_sel_t;

	// in strobes and register side controls.
	typedef struct packed {
		logic        inc_pc;
		logic        mdr_read;
		logic        inport_in;
		logic        y_in;
		logic        ir_in;
		logic        mdr_in;
		logic        pc_in;
		logic        z_in;
		logic        lo_in;
		logic        hi_in;
		logic [15:0] r_in;
	} reg_load_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_shr,
		alu_shra,
		alu_shl,
		alu_ror,
		alu_rol,
		alu_mul,
		alu_neg,
		alu_not,
		alu_inc4
	} alu_op_e;

	typedef struct packed {
		logic [4:0]  opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [14:0] unused;
	} inst_reg_t;

	typedef struct packed {
		logic [4:0]  opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [18:0] constant;
	} inst_imm_t;

	// same instruction word, register or immediate view.
	typedef union packed {
		inst_reg_t rtype;
		inst_imm_t itype;
	} inst_word_u;

	typedef logic [15:0][31:0] gpr_sources_t;

	typedef struct packed {
		logic [31:0] c_sext;
		logic [31:0] inport;
		logic [31:0] mdr;
		logic [31:0] pc;
		logic [31:0] zlow;
		logic [31:0] zhigh;
		logic [31:0] lo;
		logic [31:0] hi;
	} special_sources_t;

endpackage
